// ==== verilog/agc_pkg.sv ====
package agc_pkg;

    // input samples, signed Q1.7
    localparam int SAMPLE_W     = 8;
    localparam int SAMPLE_POINT = 7;

    // power of one sample, unsigned
    localparam int POW_W     = 2 * SAMPLE_W;
    localparam int POW_POINT = 2 * SAMPLE_POINT;

    // gain register, signed Q8.8
    localparam int GAIN_W     = 16;
    localparam int GAIN_POINT = 8;

    // loop coefficient, unsigned Q8.8
    localparam int COEF_W     = 16;
    localparam int COEF_POINT = 8;

    // full product of sample and applied gain
    localparam int OUT_W = SAMPLE_W + GAIN_W;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [POW_W-1:0]    power_t;
    typedef logic signed [GAIN_W-1:0]   gain_t;
    typedef logic        [COEF_W-1:0]   coef_t;
    typedef logic signed [OUT_W-1:0]    scaled_t;

    localparam gain_t GAIN_ONE = gain_t'(1 << GAIN_POINT);

    typedef enum logic [2:0] {
        UPD_IDLE,
        UPD_SCALE,
        UPD_COMPARE,
        UPD_ADJUST,
        UPD_COMMIT
    } update_state_t;

endpackage

// ==== verilog/avg_power.sv ====
module avg_power #(
    parameter int PARALLEL = 4,
    parameter int WINDOW   = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  agc_pkg::sample_t [PARALLEL-1:0]    din,
    input  logic                               din_valid,
    output agc_pkg::power_t                    avg_pow,
    output logic                               avg_pow_valid
);
    import agc_pkg::*;

    // room for the lane sum and for the window sum
    localparam int BEAT_W = POW_W + $clog2(PARALLEL);
    localparam int SUM_W  = BEAT_W + $clog2(WINDOW);
    localparam int SHIFT  = $clog2(WINDOW * PARALLEL);

    logic [BEAT_W-1:0] beat_acc;
    logic [BEAT_W-1:0] beat_sum;
    logic              beat_valid;
    logic [BEAT_W-1:0] delay_line [WINDOW];
    logic [SUM_W-1:0]  win_sum;

    // sum of squares over all lanes of one beat
    always_comb begin
        logic signed [POW_W-1:0] sq;
        beat_acc = '0;
        for (int i = 0; i < PARALLEL; i++) begin
            sq = din[i] * din[i];
            beat_acc = beat_acc + BEAT_W'($unsigned(sq));
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= din_valid;
        end
        if (din_valid) begin
            beat_sum <= beat_acc;
        end
    end

    // stage 2, running sum over the last WINDOW beats
    // the delay line starts empty so early beats see zeros
    always_ff @(posedge clk) begin
        if (rst) begin
            win_sum       <= '0;
            avg_pow_valid <= 1'b0;
            for (int i = 0; i < WINDOW; i++) begin
                delay_line[i] <= '0;
            end
        end else begin
            avg_pow_valid <= beat_valid;
            if (beat_valid) begin
                win_sum <= win_sum + SUM_W'(beat_sum) - SUM_W'(delay_line[WINDOW-1]);
                delay_line[0] <= beat_sum;
                for (int i = 1; i < WINDOW; i++) begin
                    delay_line[i] <= delay_line[i-1];
                end
            end
        end
    end

    // mean over WINDOW beats and PARALLEL lanes, truncated
    assign avg_pow = power_t'(win_sum >> SHIFT);

endmodule

// ==== verilog/update_timer.sv ====
module update_timer #(
    parameter int UPDATE_BEATS = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic din_valid,
    input  logic update_taken,
    output logic update_due
);

    localparam int CNT_W = (UPDATE_BEATS > 1) ? $clog2(UPDATE_BEATS) : 1;

    logic [CNT_W-1:0] beat_cnt;
    logic             last_beat;

    assign last_beat = din_valid && (beat_cnt == CNT_W'(UPDATE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            update_due <= 1'b0;
        end else begin
            if (last_beat) begin
                beat_cnt <= '0;
            end else if (din_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            // a fresh request wins over a take in the same cycle
            if (last_beat) begin
                update_due <= 1'b1;
            end else if (update_taken) begin
                update_due <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/gain_loop_fsm.sv ====
module gain_loop_fsm #(
    parameter int GAIN_HIGH = 2048,
    parameter int GAIN_LOW  = 0
) (
    input  logic            clk,
    input  logic            rst,
    input  agc_pkg::power_t avg_pow,
    input  logic            avg_pow_valid,
    input  logic            update_due,
    input  agc_pkg::power_t ref_pow,
    input  agc_pkg::coef_t  error_coef,
    output logic            update_taken,
    output agc_pkg::gain_t  gain,
    output logic            gain_valid
);
    import agc_pkg::*;

    localparam int ERR_W      = POW_W + 1;
    localparam int STEP_W     = ERR_W + COEF_W + 1;
    localparam int STEP_SHIFT = POW_POINT + COEF_POINT - GAIN_POINT;

    update_state_t            state;
    power_t                   avg_l;
    power_t                   ref_l;
    coef_t                    coef_l;
    power_t                   scaled_q;
    logic signed [ERR_W-1:0]  err_q;
    logic signed [STEP_W-1:0] step_q;
    logic signed [POW_W+GAIN_W:0] scale_prod;
    logic signed [STEP_W-1:0] step_prod;
    logic signed [STEP_W:0]   cand;
    logic                     cand_ok;
    logic                     commit_q;

    // start only with a fresh power figure at hand
    assign update_taken = (state == UPD_IDLE) && update_due && avg_pow_valid;

    always_comb begin
        scale_prod = $signed({1'b0, avg_l}) * gain;
        step_prod  = err_q * $signed({1'b0, coef_l});
        cand       = step_q + gain;
        cand_ok    = (cand > GAIN_LOW) && (cand < GAIN_HIGH);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= UPD_IDLE;
            gain       <= GAIN_ONE;
            commit_q   <= 1'b0;
            gain_valid <= 1'b0;
        end else begin
            case (state)
                UPD_IDLE: begin
                    if (update_taken) begin
                        state <= UPD_SCALE;
                    end
                end
                UPD_SCALE:   state <= UPD_COMPARE;
                UPD_COMPARE: state <= UPD_ADJUST;
                UPD_ADJUST:  state <= UPD_COMMIT;
                UPD_COMMIT: begin
                    state <= UPD_IDLE;
                    // out of range candidates leave the gain as it is
                    if (cand_ok) begin
                        gain <= gain_t'(cand);
                    end
                end
                default: state <= UPD_IDLE;
            endcase
            // one cycle later so the pulse lines up with the applied gain register
            commit_q   <= (state == UPD_COMMIT);
            gain_valid <= commit_q;
        end
    end

    // update pipeline, one step per state
    always_ff @(posedge clk) begin
        if (update_taken) begin
            avg_l  <= avg_pow;
            ref_l  <= ref_pow;
            coef_l <= error_coef;
        end
        if (state == UPD_SCALE) begin
            scaled_q <= power_t'(scale_prod >>> GAIN_POINT);
        end
        // positive error means the output is too weak
        if (state == UPD_COMPARE) begin
            err_q <= $signed({1'b0, ref_l}) - $signed({1'b0, scaled_q});
        end
        if (state == UPD_ADJUST) begin
            step_q <= step_prod >>> STEP_SHIFT;
        end
    end

endmodule

// ==== verilog/gain_apply.sv ====
module gain_apply #(
    parameter int PARALLEL = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  agc_pkg::sample_t [PARALLEL-1:0] din,
    input  logic                            din_valid,
    input  agc_pkg::gain_t                  gain,
    output agc_pkg::scaled_t [PARALLEL-1:0] dout,
    output logic                            dout_valid,
    output agc_pkg::gain_t                  applied_gain
);
    import agc_pkg::*;

    gain_t                  applied_q;
    scaled_t [PARALLEL-1:0] prod_q;
    logic                   prod_valid;

    // sqrt(g) is close to g/2 + 0.5 around unity gain
    always_ff @(posedge clk) begin
        if (rst) begin
            applied_q <= GAIN_ONE;
        end else begin
            applied_q <= (gain >>> 1) + (GAIN_ONE >>> 1);
        end
    end

    assign applied_gain = applied_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            prod_valid <= din_valid;
            dout_valid <= prod_valid;
        end
    end

    // Q1.7 times Q8.8 gives a product with point 15
    always_ff @(posedge clk) begin
        if (din_valid) begin
            for (int i = 0; i < PARALLEL; i++) begin
                prod_q[i] <= din[i] * applied_q;
            end
        end
        if (prod_valid) begin
            dout <= prod_q;
        end
    end

endmodule

// ==== verilog/agc_top.sv ====
module agc_top #(
    parameter int PARALLEL     = 4,
    parameter int WINDOW       = 16,
    parameter int UPDATE_BEATS = 32,
    parameter int GAIN_HIGH    = 2048,
    parameter int GAIN_LOW     = 0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  agc_pkg::sample_t [PARALLEL-1:0] din,
    input  logic                            din_valid,
    input  agc_pkg::power_t                 ref_pow,
    input  agc_pkg::coef_t                  error_coef,
    output agc_pkg::scaled_t [PARALLEL-1:0] dout,
    output logic                            dout_valid,
    output agc_pkg::gain_t                  gain_out,
    output logic                            gain_out_valid
);
    import agc_pkg::*;

    power_t avg_pow;
    logic   avg_pow_valid;
    logic   update_due;
    logic   update_taken;
    gain_t  gain;

    // windowed mean power of the input stream
    avg_power #(
        .PARALLEL (PARALLEL),
        .WINDOW   (WINDOW)
    ) u_avg_power (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .din_valid     (din_valid),
        .avg_pow       (avg_pow),
        .avg_pow_valid (avg_pow_valid)
    );

    update_timer #(
        .UPDATE_BEATS (UPDATE_BEATS)
    ) u_update_timer (
        .clk          (clk),
        .rst          (rst),
        .din_valid    (din_valid),
        .update_taken (update_taken),
        .update_due   (update_due)
    );

    gain_loop_fsm #(
        .GAIN_HIGH (GAIN_HIGH),
        .GAIN_LOW  (GAIN_LOW)
    ) u_gain_loop_fsm (
        .clk           (clk),
        .rst           (rst),
        .avg_pow       (avg_pow),
        .avg_pow_valid (avg_pow_valid),
        .update_due    (update_due),
        .ref_pow       (ref_pow),
        .error_coef    (error_coef),
        .update_taken  (update_taken),
        .gain          (gain),
        .gain_valid    (gain_out_valid)
    );

    // samples scaled by the applied gain, 2 cycles latency
    gain_apply #(
        .PARALLEL (PARALLEL)
    ) u_gain_apply (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid    (din_valid),
        .gain         (gain),
        .dout         (dout),
        .dout_valid   (dout_valid),
        .applied_gain (gain_out)
    );

endmodule

// ==== sim/agc_properties.sv ====
module agc_properties #(
    parameter int GAIN_HIGH = 2048,
    parameter int GAIN_LOW  = 0
) (
    input logic           clk,
    input logic           rst,
    input agc_pkg::gain_t gain,
    input logic           gain_valid,
    input logic           update_due,
    input logic           update_taken
);
    timeunit 1ns;
    timeprecision 100ps;
    import agc_pkg::*;

    // read by the testbench monitor
    int violations = 0;

    // gain stays in range, reset value aside
    gain_in_bounds: assert property (@(posedge clk) disable iff (rst)
        ((gain > GAIN_LOW) && (gain < GAIN_HIGH)) || (gain == GAIN_ONE))
    else begin
        $error("gain %h outside its bounds", gain);
        violations++;
    end

    gain_valid_single: assert property (@(posedge clk) disable iff (rst)
        gain_valid |=> !gain_valid)
    else begin
        $error("gain_valid high in two consecutive cycles");
        violations++;
    end

    // a pending request is held until the loop takes it
    due_held_until_taken: assert property (@(posedge clk) disable iff (rst)
        (update_due && !update_taken) |=> update_due)
    else begin
        $error("update_due dropped before update_taken");
        violations++;
    end

endmodule

bind gain_loop_fsm agc_properties #(
    .GAIN_HIGH (GAIN_HIGH),
    .GAIN_LOW  (GAIN_LOW)
) props (
    .clk          (clk),
    .rst          (rst),
    .gain         (gain),
    .gain_valid   (gain_valid),
    .update_due   (update_due),
    .update_taken (update_taken)
);

// ==== sim/agc_tb.sv ====
module agc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import agc_pkg::*;

    localparam int PARALLEL     = 4;
    localparam int WINDOW       = 16;
    localparam int UPDATE_BEATS = 32;
    localparam int GAIN_HIGH    = 2048;
    localparam int GAIN_LOW     = 0;
    localparam int NUM_PHASES   = 5;
    localparam int GAP_CYCLES   = 8;

    logic                   clk = 1'b0;
    logic                   rst;
    sample_t [PARALLEL-1:0] din;
    logic                   din_valid;
    power_t                 ref_pow;
    coef_t                  error_coef;
    scaled_t [PARALLEL-1:0] dout;
    logic                   dout_valid;
    gain_t                  gain_out;
    logic                   gain_out_valid;

    // one row per phase: lane amplitude, ref_pow, error_coef, beats
    // frozen, rise, fall, rejected step, rise at a new amplitude
    int phase_amp   [NUM_PHASES] = '{40, 64, 64, 64, 100};
    int phase_ref   [NUM_PHASES] = '{1000, 8192, 1024, 65535, 12000};
    int phase_coef  [NUM_PHASES] = '{0, 256, 512, 65535, 128};
    int phase_beats [NUM_PHASES] = '{64, 96, 64, 32, 64};

    integer seed = 84274;
    int     cyc = 0;
    bit     failed = 1'b0;
    int     pulses = 0;

    // reference model state
    int  model_gain = 256;
    int  model_applied = 256;
    int  next_applied;
    int  switch_cyc;
    bit  pending = 1'b0;
    int  beat_count = 0;
    int  beat_pow [$];
    logic [PARALLEL*OUT_W-1:0] exp_dout [$];
    int  exp_cycle [$];
    int  exp_gain [$];

    agc_top #(
        .PARALLEL     (PARALLEL),
        .WINDOW       (WINDOW),
        .UPDATE_BEATS (UPDATE_BEATS),
        .GAIN_HIGH    (GAIN_HIGH),
        .GAIN_LOW     (GAIN_LOW)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .din            (din),
        .din_valid      (din_valid),
        .ref_pow        (ref_pow),
        .error_coef     (error_coef),
        .dout           (dout),
        .dout_valid     (dout_valid),
        .gain_out       (gain_out),
        .gain_out_valid (gain_out_valid)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string what);
        failed = 1'b1;
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // mean over the last WINDOW beats, missing beats as zero
    function automatic int window_avg();
        int sum;
        sum = 0;
        for (int k = 0; k < WINDOW && k < beat_pow.size(); k++) begin
            sum += beat_pow[beat_pow.size()-1-k];
        end
        return sum / (WINDOW * PARALLEL);
    endfunction

    // one loop update: scale, compare, adjust, bounded commit
    function automatic int next_gain(input int g, input int avg, input int refp, input int coef);
        longint scaled;
        longint err;
        longint step;
        longint cand;
        scaled = ((longint'(avg) * g) >>> GAIN_POINT) & 64'hffff;
        err    = refp - scaled;
        step   = (err * coef) >>> (POW_POINT + COEF_POINT - GAIN_POINT);
        cand   = g + step;
        if (cand > GAIN_LOW && cand < GAIN_HIGH) begin
            return int'(cand);
        end
        return g;
    endfunction

    task automatic drive_beat(input int amp, input int refp, input int coef);
        int s;
        int pow;
        logic [PARALLEL*OUT_W-1:0] want;
        @(negedge clk);
        // new applied gain reaches beats captured 7 cycles after the update beat
        if (pending && cyc >= switch_cyc) begin
            model_applied = next_applied;
            pending = 1'b0;
        end
        din_valid  = 1'b1;
        ref_pow    = power_t'(refp);
        error_coef = coef_t'(coef);
        pow = 0;
        for (int i = 0; i < PARALLEL; i++) begin
            s = ($random(seed) & 1) ? -amp : amp;
            din[i] = sample_t'(s);
            want[i*OUT_W +: OUT_W] = OUT_W'(s * model_applied);
            pow += s * s;
        end
        exp_dout.push_back(want);
        exp_cycle.push_back(cyc + 2);
        beat_count++;
        // the loop latches the window as it stood one beat earlier
        if (beat_count % UPDATE_BEATS == 0) begin
            model_gain   = next_gain(model_gain, window_avg(), refp, coef);
            next_applied = (model_gain >>> 1) + 128;
            exp_gain.push_back(next_applied);
            pending    = 1'b1;
            switch_cyc = cyc + 7;
        end
        beat_pow.push_back(pow);
        if (beat_pow.size() > WINDOW) begin
            void'(beat_pow.pop_front());
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        din_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        logic [PARALLEL*OUT_W-1:0] want;
        int when;
        int g;
        cyc <= cyc + 1;
        if (!rst) begin
            if (dout_valid) begin
                assert (exp_dout.size() > 0)
                else report_failure("dout_valid came with no beat outstanding");
                want = exp_dout.pop_front();
                when = exp_cycle.pop_front();
                assert (when == cyc)
                else report_failure("dout arrived at the wrong cycle after its beat");
                for (int i = 0; i < PARALLEL; i++) begin
                    assert (dout[i] == want[i*OUT_W +: OUT_W])
                    else report_failure($sformatf("ERR dout[%0d] got %h expected %h",
                        i, dout[i], want[i*OUT_W +: OUT_W]));
                end
            end
            if (gain_out_valid) begin
                pulses++;
                assert (exp_gain.size() > 0)
                else report_failure("gain_out_valid pulsed with no update due");
                g = exp_gain.pop_front();
                assert (gain_out == gain_t'(g))
                else report_failure($sformatf("ERR gain_out got %h expected %h",
                    gain_out, gain_t'(g)));
            end
            assert (dut.u_gain_loop_fsm.props.violations == 0)
            else report_failure("a bound assertion on the gain loop fired");
        end
    end

    initial begin
        int total;
        total = 0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            total += phase_beats[p];
        end
        #((total * 4 + 1000) * 20);
        $display("watchdog expired before the test finished");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        int total;
        int waited;
        total      = 0;
        rst        = 1'b1;
        din        = '0;
        din_valid  = 1'b0;
        ref_pow    = '0;
        error_coef = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (gain_out == GAIN_ONE)
            else report_failure($sformatf("ERR gain_out got %h expected %h", gain_out, GAIN_ONE));
            assert (!dout_valid && !gain_out_valid)
            else report_failure("a valid output rose after reset with no input");
        end
        for (int p = 0; p < NUM_PHASES; p++) begin
            for (int b = 0; b < phase_beats[p]; b++) begin
                drive_beat(phase_amp[p], phase_ref[p], phase_coef[p]);
            end
            // ref_pow and error_coef hold while the last update runs
            repeat (GAP_CYCLES) idle_cycle();
            total += phase_beats[p];
        end
        waited = 0;
        while ((exp_dout.size() > 0 || exp_gain.size() > 0) && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_dout.size() == 0 && exp_gain.size() == 0)
        else report_failure("outputs still missing after the drain timeout");
        assert (pulses == total / UPDATE_BEATS)
        else report_failure($sformatf("ERR gain_out_valid count got %h expected %h",
            pulses, total / UPDATE_BEATS));
        if (!failed) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== verilog.f ====
verilog/agc_pkg.sv
verilog/avg_power.sv
verilog/update_timer.sv
verilog/gain_loop_fsm.sv
verilog/gain_apply.sv
verilog/agc_top.sv
sim/agc_properties.sv
sim/agc_tb.sv

// ==== Bender.yml ====
package:
  name: agc

sources:
  - files:
      - verilog/agc_pkg.sv
      - verilog/avg_power.sv
      - verilog/update_timer.sv
      - verilog/gain_loop_fsm.sv
      - verilog/gain_apply.sv
      - verilog/agc_top.sv
  - target: simulation
    files:
      - sim/agc_properties.sv
      - sim/agc_tb.sv
